// File: hdl/decodeStage.sv
/*
   Eight-entry register file, written from W on the clock edge with no read bypass.
   Registers clear to zero on reset. J reads no register and resolves in execute
   as BEQZ on a zero operand.
*/
`timescale 1ns/1ps
module decodeStage (
    input  logic           clk,
    input  logic           rstN,
    input  wiscPkg::instrT instD,
    input  logic [15:0]    pcD,
    input  logic           branchInstD,
    input  logic           haltD,
    input  logic           wbEn,
    input  logic [2:0]     wbReg,
    input  logic [15:0]    wbData,
    output logic           regWrtD,
    output logic [2:0]     wrtRegD,
    output logic [15:0]    rsVal,
    output logic [15:0]    rtVal,
    output logic [15:0]    immX,
    output logic [2:0]     aluOpX,
    output logic           regWrtX,
    output logic [2:0]     wrtRegX,
    output logic           memRdX,
    output logic           memWrX,
    output logic           branchInstX,
    output logic [1:0]     brCondX,
    output logic           jumpRegX,
    output logic           pcRelX,
    output logic           haltX,
    output logic [15:0]    pcX
);
    import wiscPkg::*;

    logic [15:0] regFile [8];
    logic [4:0]  opc;
    logic        isArith;
    logic        isImm;
    logic        isBr;
    logic        isJ;
    logic        isJr;
    logic        isSt;
    logic        isLd;
    logic [15:0] immD;
    logic [2:0]  aluOpD;

    assign opc     = instD.regFmt.opcode;
    assign isArith = (opc == OP_ARITH);
    assign isImm   = (opc[4:2] == OP_IMM[4:2]);
    assign isBr    = (opc[4:2] == OP_BR[4:2]);
    assign isJ     = (opc == OP_J);
    assign isJr    = (opc == OP_JR);
    assign isSt    = (opc == OP_ST);
    assign isLd    = (opc == OP_LD);

    // Also feeds the hazard check in fetch
    assign regWrtD = isArith || isImm || isLd;
    assign wrtRegD = isArith ? instD.regFmt.rd : instD.immFmt.rd;

    always_comb begin
        if (isJ) begin
            immD = {{5{instD.brFmt.rs[2]}}, instD.brFmt.rs, instD.brFmt.disp};
        end else if (isBr || isJr) begin
            immD = {{8{instD.brFmt.disp[7]}}, instD.brFmt.disp};
        end else begin
            immD = {{11{instD.immFmt.imm[4]}}, instD.immFmt.imm};
        end
    end

    // Bit 2 selects the immediate operand and ST and LD use the add
    always_comb begin
        if (isArith) begin
            aluOpD = {1'b0, instD.regFmt.func};
        end else if (isImm) begin
            aluOpD = {1'b1, opc[1:0]};
        end else begin
            aluOpD = 3'b100;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbEn) begin
            regFile[wbReg] <= wbData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWrtX     <= 1'b0;
            memRdX      <= 1'b0;
            memWrX      <= 1'b0;
            branchInstX <= 1'b0;
            jumpRegX    <= 1'b0;
            pcRelX      <= 1'b0;
            haltX       <= 1'b0;
        end else begin
            regWrtX     <= regWrtD;
            memRdX      <= isLd;
            memWrX      <= isSt;
            branchInstX <= branchInstD;
            jumpRegX    <= isJr;
            pcRelX      <= isBr || isJ;
            haltX       <= haltD;
        end
    end

    // For ST the Rt slot holds the store data register in the bits of immFmt.rd
    always_ff @(posedge clk) begin
        rsVal   <= isJ ? 16'h0000 : regFile[instD.regFmt.rs];
        rtVal   <= regFile[instD.regFmt.rt];
        immX    <= immD;
        aluOpX  <= aluOpD;
        wrtRegX <= wrtRegD;
        brCondX <= opc[1:0];
        pcX     <= pcD;
    end

endmodule

// File: hdl/executeStage.sv
/*
   ALU, memory address adder and branch resolution. Redirect is combinational
   and valid only in the cycle the control instruction sits in X.
*/
`timescale 1ns/1ps
module executeStage (
    input  logic        clk,
    input  logic        rstN,
    input  logic [15:0] rsVal,
    input  logic [15:0] rtVal,
    input  logic [15:0] immX,
    input  logic [2:0]  aluOpX,
    input  logic        regWrtX,
    input  logic [2:0]  wrtRegX,
    input  logic        memRdX,
    input  logic        memWrX,
    input  logic        branchInstX,
    input  logic [1:0]  brCondX,
    input  logic        jumpRegX,
    input  logic        pcRelX,
    input  logic        haltX,
    input  logic [15:0] pcX,
    output logic        redirect,
    output logic [15:0] redirectPc,
    output logic [15:0] aluResM,
    output logic [15:0] storeValM,
    output logic        regWrtM,
    output logic [2:0]  wrtRegM,
    output logic        memRdM,
    output logic        memWrM,
    output logic        haltM
);

    logic [15:0] aluB;
    logic [15:0] aluRes;
    logic        condMet;

    assign aluB = aluOpX[2] ? immX : rtVal;

    always_comb begin
        case (aluOpX[1:0])
            2'b00:   aluRes = rsVal + aluB;
            2'b01:   aluRes = aluB - rsVal;
            2'b10:   aluRes = rsVal ^ aluB;
            default: aluRes = rsVal & ~aluB;
        endcase
    end

    // EQZ, NEZ, LTZ, GEZ on Rs
    always_comb begin
        case (brCondX)
            2'b00:   condMet = (rsVal == 16'h0000);
            2'b01:   condMet = (rsVal != 16'h0000);
            2'b10:   condMet = rsVal[15];
            default: condMet = !rsVal[15];
        endcase
    end

    assign redirect   = branchInstX && (jumpRegX || condMet);
    assign redirectPc = (pcRelX ? pcX : rsVal) + immX;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWrtM <= 1'b0;
            memRdM  <= 1'b0;
            memWrM  <= 1'b0;
            haltM   <= 1'b0;
        end else begin
            regWrtM <= regWrtX;
            memRdM  <= memRdX;
            memWrM  <= memWrX;
            haltM   <= haltX;
        end
    end

    always_ff @(posedge clk) begin
        aluResM   <= aluRes;
        storeValM <= rtVal;
        wrtRegM   <= wrtRegX;
    end

endmodule

// File: hdl/fetchStage.sv
/*
   Word-addressed PC fetching from a combinational instruction ROM.
   A redirect wins over a stall. After a HALT passes, only NOPs are issued.
*/
`timescale 1ns/1ps
module fetchStage (
    input  logic           clk,
    input  logic           rstN,
    input  logic [15:0]    imemData,
    input  logic           redirect,
    input  logic [15:0]    redirectPc,
    input  logic           regWrtD,
    input  logic           regWrtX,
    input  logic           regWrtM,
    input  logic           regWrtW,
    input  logic [2:0]     wrtRegD,
    input  logic [2:0]     wrtRegX,
    input  logic [2:0]     wrtRegM,
    input  logic [2:0]     wrtRegW,
    input  logic           branchInstX,
    output logic [15:0]    imemAddr,
    output wiscPkg::instrT instD,
    output logic [15:0]    pcD,
    output logic           branchInstD,
    output logic           haltD
);
    import wiscPkg::*;

    logic [15:0] pc;
    logic        haltSeen;
    instrT       nextInst;
    logic        pcNop;
    logic        branchInstF;
    logic        haltF;

    hazardDet hazardDet_inst (
        .fetchInst   (imemData),
        .regWrtD     (regWrtD),
        .regWrtX     (regWrtX),
        .regWrtM     (regWrtM),
        .regWrtW     (regWrtW),
        .wrtRegD     (wrtRegD),
        .wrtRegX     (wrtRegX),
        .wrtRegM     (wrtRegM),
        .wrtRegW     (wrtRegW),
        .branchInstD (branchInstD),
        .branchInstX (branchInstX),
        .haltSeen    (haltSeen),
        .nextInst    (nextInst),
        .pcNop       (pcNop),
        .branchInstF (branchInstF),
        .haltF       (haltF)
    );

    assign imemAddr = pc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc          <= '0;
            haltSeen    <= 1'b0;
            instD       <= NOP_INST;
            branchInstD <= 1'b0;
            haltD       <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirectPc;
            end else if (!pcNop) begin
                pc <= pc + 16'd1;
            end
            haltSeen    <= haltSeen || haltF;
            instD       <= nextInst;
            branchInstD <= branchInstF;
            haltD       <= haltF;
        end
    end

    // Sequential PC of the word in D used as the base of PC-relative targets
    always_ff @(posedge clk) begin
        pcD <= pc + 16'd1;
    end

endmodule

// File: hdl/hazardDet.sv
/*
   Stalls fetch on a RAW match against any older writing stage, and while a
   control-flow instruction sits in D or X. No forwarding, so W is checked too.
   A stalled fetch is replaced by NOP_INST and the PC is held.
*/
`timescale 1ns/1ps
module hazardDet (
    input  wiscPkg::instrT fetchInst,
    input  logic           regWrtD,
    input  logic           regWrtX,
    input  logic           regWrtM,
    input  logic           regWrtW,
    input  logic [2:0]     wrtRegD,
    input  logic [2:0]     wrtRegX,
    input  logic [2:0]     wrtRegM,
    input  logic [2:0]     wrtRegW,
    input  logic           branchInstD,
    input  logic           branchInstX,
    input  logic           haltSeen,
    output wiscPkg::instrT nextInst,
    output logic           pcNop,
    output logic           branchInstF,
    output logic           haltF
);
    import wiscPkg::*;

    logic [4:0] opc;
    logic       isCtrl;
    logic       readsRs;
    logic       readsMid;
    logic       rsBusy;
    logic       midBusy;

    // True when an older stage will still write this register
    function automatic logic pending(input logic [2:0] r);
        return (regWrtD && r == wrtRegD) || (regWrtX && r == wrtRegX) ||
               (regWrtM && r == wrtRegM) || (regWrtW && r == wrtRegW);
    endfunction

    assign opc = fetchInst.regFmt.opcode;

    always_comb begin
        isCtrl   = 1'b0;
        readsRs  = 1'b0;
        readsMid = 1'b0;
        if (opc == OP_J) begin
            isCtrl = 1'b1;
        end else if (opc == OP_JR || opc[4:2] == OP_BR[4:2]) begin
            isCtrl  = 1'b1;
            readsRs = 1'b1;
        end else if (opc[4:2] == OP_IMM[4:2] || opc == OP_LD) begin
            readsRs = 1'b1;
        end else if (opc == OP_ARITH || opc == OP_ST) begin
            readsRs  = 1'b1;
            readsMid = 1'b1;
        end
    end

    // Middle field is Rt for arithmetic and the data register for ST
    assign rsBusy  = readsRs && pending(fetchInst.regFmt.rs);
    assign midBusy = readsMid && pending(fetchInst.regFmt.rt);

    assign pcNop       = rsBusy || midBusy || branchInstD || branchInstX || haltSeen;
    assign nextInst    = pcNop ? NOP_INST : fetchInst;
    assign branchInstF = isCtrl && !pcNop;
    assign haltF       = (opc == OP_HALT) && !pcNop;

endmodule

// File: hdl/memStage.sv
/*
   Word-addressed data memory with a combinational read and a clocked write.
   Contents are not cleared by reset. halted is sticky once a HALT reaches W.
*/
`timescale 1ns/1ps
module memStage (
    input  logic        clk,
    input  logic        rstN,
    input  logic [15:0] aluResM,
    input  logic [15:0] storeValM,
    input  logic        regWrtM,
    input  logic [2:0]  wrtRegM,
    input  logic        memRdM,
    input  logic        memWrM,
    input  logic        haltM,
    output logic        wbEn,
    output logic [2:0]  wbReg,
    output logic [15:0] wbData,
    output logic        halted
);
    import wiscPkg::*;

    logic [15:0]               dmem [DMEM_WORDS];
    logic [DMEM_ADDR_BITS-1:0] addr;

    assign addr = aluResM[DMEM_ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (memWrM) begin
            dmem[addr] <= storeValM;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbEn   <= 1'b0;
            halted <= 1'b0;
        end else begin
            wbEn   <= regWrtM;
            halted <= halted || haltM;
        end
    end

    always_ff @(posedge clk) begin
        wbReg  <= wrtRegM;
        wbData <= memRdM ? dmem[addr] : aluResM;
    end

endmodule

// File: hdl/wiscPipe.sv
/*
   Five-stage in-order pipeline without forwarding. Instruction memory is external
   and must answer imemAddr combinationally in the same cycle.
*/
`timescale 1ns/1ps
module wiscPipe (
    input  logic        clk,
    input  logic        rstN,
    output logic [15:0] imemAddr,
    input  logic [15:0] imemData,
    output logic        wbEn,
    output logic [2:0]  wbReg,
    output logic [15:0] wbData,
    output logic        halted
);

    // Fetch to decode
    logic [15:0] instD;
    logic [15:0] pcD;
    logic        branchInstD;
    logic        haltD;
    logic        regWrtD;
    logic [2:0]  wrtRegD;

    // Decode to execute
    logic [15:0] rsVal;
    logic [15:0] rtVal;
    logic [15:0] immX;
    logic [2:0]  aluOpX;
    logic        regWrtX;
    logic [2:0]  wrtRegX;
    logic        memRdX;
    logic        memWrX;
    logic        branchInstX;
    logic [1:0]  brCondX;
    logic        jumpRegX;
    logic        pcRelX;
    logic        haltX;
    logic [15:0] pcX;

    // Execute to memory, and back to fetch
    logic        redirect;
    logic [15:0] redirectPc;
    logic [15:0] aluResM;
    logic [15:0] storeValM;
    logic        regWrtM;
    logic [2:0]  wrtRegM;
    logic        memRdM;
    logic        memWrM;
    logic        haltM;

    fetchStage fetchStage_inst (
        .clk         (clk),
        .rstN        (rstN),
        .imemData    (imemData),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .regWrtD     (regWrtD),
        .regWrtX     (regWrtX),
        .regWrtM     (regWrtM),
        .regWrtW     (wbEn),
        .wrtRegD     (wrtRegD),
        .wrtRegX     (wrtRegX),
        .wrtRegM     (wrtRegM),
        .wrtRegW     (wbReg),
        .branchInstX (branchInstX),
        .imemAddr    (imemAddr),
        .instD       (instD),
        .pcD         (pcD),
        .branchInstD (branchInstD),
        .haltD       (haltD)
    );

    decodeStage decodeStage_inst (
        .clk         (clk),
        .rstN        (rstN),
        .instD       (instD),
        .pcD         (pcD),
        .branchInstD (branchInstD),
        .haltD       (haltD),
        .wbEn        (wbEn),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .regWrtD     (regWrtD),
        .wrtRegD     (wrtRegD),
        .rsVal       (rsVal),
        .rtVal       (rtVal),
        .immX        (immX),
        .aluOpX      (aluOpX),
        .regWrtX     (regWrtX),
        .wrtRegX     (wrtRegX),
        .memRdX      (memRdX),
        .memWrX      (memWrX),
        .branchInstX (branchInstX),
        .brCondX     (brCondX),
        .jumpRegX    (jumpRegX),
        .pcRelX      (pcRelX),
        .haltX       (haltX),
        .pcX         (pcX)
    );

    executeStage executeStage_inst (
        .clk         (clk),
        .rstN        (rstN),
        .rsVal       (rsVal),
        .rtVal       (rtVal),
        .immX        (immX),
        .aluOpX      (aluOpX),
        .regWrtX     (regWrtX),
        .wrtRegX     (wrtRegX),
        .memRdX      (memRdX),
        .memWrX      (memWrX),
        .branchInstX (branchInstX),
        .brCondX     (brCondX),
        .jumpRegX    (jumpRegX),
        .pcRelX      (pcRelX),
        .haltX       (haltX),
        .pcX         (pcX),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .aluResM     (aluResM),
        .storeValM   (storeValM),
        .regWrtM     (regWrtM),
        .wrtRegM     (wrtRegM),
        .memRdM      (memRdM),
        .memWrM      (memWrM),
        .haltM       (haltM)
    );

    // Its output register is the W stage
    memStage memStage_inst (
        .clk       (clk),
        .rstN      (rstN),
        .aluResM   (aluResM),
        .storeValM (storeValM),
        .regWrtM   (regWrtM),
        .wrtRegM   (wrtRegM),
        .memRdM    (memRdM),
        .memWrM    (memWrM),
        .haltM     (haltM),
        .wbEn      (wbEn),
        .wbReg     (wbReg),
        .wbData    (wbData),
        .halted    (halted)
    );

endmodule

// File: hdl/wiscPkg.sv
/*
   Opcodes, NOP word and instruction formats of the 16-bit teaching ISA subset.
   Immediates and displacements are sign-extended. SUB and SUBI compute the second
   operand minus Rs. Data memory is word addressed and indexed by the low address bits.
*/
package wiscPkg;

    // Major opcodes, instruction bits [15:11]
    localparam logic [4:0] OP_HALT  = 5'b00000;
    localparam logic [4:0] OP_NOP   = 5'b00001;
    localparam logic [4:0] OP_J     = 5'b00100;
    localparam logic [4:0] OP_JR    = 5'b00101;
    // ADDI, SUBI, XORI, ANDNI in the low two bits
    localparam logic [4:0] OP_IMM   = 5'b01000;
    // BEQZ, BNEZ, BLTZ, BGEZ in the low two bits
    localparam logic [4:0] OP_BR    = 5'b01100;
    localparam logic [4:0] OP_ST    = 5'b10000;
    localparam logic [4:0] OP_LD    = 5'b10001;
    // ADD, SUB, XOR, ANDN in the function field
    localparam logic [4:0] OP_ARITH = 5'b11011;

    localparam logic [15:0] NOP_INST = {OP_NOP, 11'b0};

    localparam int DMEM_WORDS     = 256;
    localparam int DMEM_ADDR_BITS = $clog2(DMEM_WORDS);

    // Every view shares the opcode and Rs positions
    typedef union packed {
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [2:0] rt;
            logic [2:0] rd;
            logic [1:0] func;
        } regFmt;
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [2:0] rd;
            logic [4:0] imm;
        } immFmt;
        // J takes {rs, disp} as an 11-bit displacement
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [7:0] disp;
        } brFmt;
    } instrT;

endpackage

// File: verification/tbWiscPipe.sv
/*
   Random forward-only programs, each ending in HALT, run from reset.
   r7 stays zero and serves as the memory and JR base, so a first program
   stores zero to every data word that later loads can reach.
*/
`timescale 1ns/1ps
module tbWiscPipe;
    import wiscPkg::*;

    localparam int PROG_LEN  = 24;
    localparam int NUM_PROGS = 6;
    localparam int ROM_WORDS = 64;

    logic        clk;
    logic        rstN;
    logic [15:0] imemAddr;
    logic [15:0] imemData;
    logic        wbEn;
    logic [2:0]  wbReg;
    logic [15:0] wbData;
    logic        halted;

    logic [15:0] rom [ROM_WORDS];
    int          progLen = 0;
    logic [15:0] regs [8];
    logic [15:0] mem [DMEM_WORDS];
    logic [2:0]  expReg [$];
    logic [15:0] expData [$];
    logic [31:0] rngState = 32'h8a0729f6;
    int          errors = 0;
    int          checks = 0;
    int          seenWrites = 0;
    int          expCount = 0;
    logic        running = 1'b0;
    int          wdCycles = 0;

    wiscPipe wiscPipe_inst (
        .clk      (clk),
        .rstN     (rstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbEn     (wbEn),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .halted   (halted)
    );

    // Combinational instruction ROM that returns NOPs past the end of the program
    assign imemData = (imemAddr < progLen) ? rom[imemAddr[5:0]] : NOP_INST;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int randBelow(input int n);
        rngState = xorshift32(rngState);
        return int'(rngState % n);
    endfunction

    // SUB forms take the second operand minus Rs and ANDN clears the second's bits
    function automatic logic [15:0] aluRule(input logic [1:0] fn, input logic [15:0] a,
                                            input logic [15:0] b);
        case (fn)
            2'b00:   return a + b;
            2'b01:   return b - a;
            2'b10:   return a ^ b;
            default: return a & ~b;
        endcase
    endfunction

    function automatic logic takenRule(input logic [1:0] cond, input logic [15:0] a);
        case (cond)
            2'b00:   return a == 16'h0000;
            2'b01:   return a != 16'h0000;
            2'b10:   return a[15];
            default: return !a[15];
        endcase
    endfunction

    task automatic expectWrite(input logic [2:0] r, input logic [15:0] v);
        regs[r] = v;
        expReg.push_back(r);
        expData.push_back(v);
    endtask

    // Runs the ROM at ISA level into the ordered list of register writes
    task automatic runModel();
        instrT       ins;
        int          pc;
        int          nextPc;
        logic [4:0]  op;
        logic [15:0] a;
        logic [15:0] addr;
        expReg.delete();
        expData.delete();
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        pc = 0;
        ins = rom[0];
        while (pc < progLen && ins.regFmt.opcode != OP_HALT) begin
            op = ins.regFmt.opcode;
            a = regs[ins.regFmt.rs];
            addr = a + {{11{ins.immFmt.imm[4]}}, ins.immFmt.imm};
            nextPc = pc + 1;
            if (op == OP_ARITH) begin
                expectWrite(ins.regFmt.rd, aluRule(ins.regFmt.func, a, regs[ins.regFmt.rt]));
            end else if (op[4:2] == OP_IMM[4:2]) begin
                expectWrite(ins.immFmt.rd,
                            aluRule(op[1:0], a, {{11{ins.immFmt.imm[4]}}, ins.immFmt.imm}));
            end else if (op == OP_ST) begin
                mem[addr[DMEM_ADDR_BITS-1:0]] = regs[ins.immFmt.rd];
            end else if (op == OP_LD) begin
                expectWrite(ins.immFmt.rd, mem[addr[DMEM_ADDR_BITS-1:0]]);
            end else if (op[4:2] == OP_BR[4:2] && takenRule(op[1:0], a)) begin
                nextPc = pc + 1 + int'($signed(ins.brFmt.disp));
            end else if (op == OP_J) begin
                nextPc = pc + 1 + int'($signed({ins.brFmt.rs, ins.brFmt.disp}));
            end else if (op == OP_JR) begin
                nextPc = int'(a + {{8{ins.brFmt.disp[7]}}, ins.brFmt.disp});
            end
            pc = nextPc;
            ins = rom[pc];
        end
    endtask

    task automatic loadInitProgram();
        for (int a = 0; a < 32; a++) begin
            rom[a] = {OP_ST, 3'd7, 3'd7, 5'(a)};
        end
        rom[32] = {OP_HALT, 11'b0};
        progLen = 33;
    endtask

    // Mode 0 ALU only, mode 1 stores and loads, mode 2 control flow mixed in
    task automatic genProgram(input int mode);
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [4:0] imm;
        logic [4:0] lastStImm;
        logic       lastWasSt;
        int         kind;
        int         room;
        int         skip;
        lastWasSt = 1'b0;
        lastStImm = '0;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            rs   = 3'(randBelow(4));
            rt   = 3'(randBelow(4));
            rd   = 3'(randBelow(4));
            imm  = 5'(randBelow(32));
            kind = randBelow(8);
            skip = 1 + randBelow(4);
            // Largest skip whose target is still at or before the HALT
            room = PROG_LEN - 2 - i;
            if (mode == 1 && lastWasSt && randBelow(2) == 0) begin
                rom[i] = {OP_LD, 3'd7, rd, lastStImm};
            end else if (mode == 1 && kind >= 3) begin
                imm = 5'(randBelow(4));
                rom[i] = (kind < 6) ? {OP_ST, 3'd7, rt, imm} : {OP_LD, 3'd7, rd, imm};
            end else if ((mode == 0 && kind < 4) || (mode == 2 && kind == 2)) begin
                rom[i] = {OP_ARITH, rs, rt, rd, 2'(randBelow(4))};
            end else if (mode == 2 && kind == 3) begin
                rom[i] = {OP_LD, 3'd7, rd, 5'(randBelow(4))};
            end else if (mode == 2 && kind >= 4 && skip <= room) begin
                case (kind)
                    4, 5:    rom[i] = {OP_BR[4:2], 2'(randBelow(4)), rs, 8'(skip)};
                    6:       rom[i] = {OP_J, 11'(skip)};
                    default: rom[i] = {OP_JR, 3'd7, 8'(i + 1 + skip)};
                endcase
            end else begin
                rom[i] = {OP_IMM[4:2], 2'(randBelow(4)), rs, rd, imm};
            end
            lastWasSt = (rom[i][15:11] == OP_ST);
            lastStImm = rom[i][4:0];
        end
        rom[PROG_LEN-1] = {OP_HALT, 11'b0};
        progLen = PROG_LEN;
    endtask

    task automatic applyReset();
        @(negedge clk);
        rstN = 1'b0;
        repeat (16) begin
            @(negedge clk);
            checks++;
            if (wbEn !== 1'b0 || halted !== 1'b0) begin
                errors++;
                $display("Error at time %0t: wbEn = %b, halted = %b in reset, expected 0, 0",
                         $time, wbEn, halted);
            end
        end
        rstN = 1'b1;
        @(negedge clk);
        checks++;
        if (wbEn !== 1'b0 || halted !== 1'b0) begin
            errors++;
            $display("Error at time %0t: wbEn = %b, halted = %b after reset, expected 0, 0",
                     $time, wbEn, halted);
        end
    endtask

    task automatic runProgram();
        runModel();
        expCount = expReg.size();
        seenWrites = 0;
        applyReset();
        running = 1'b1;
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        @(negedge clk);
        running = 1'b0;
        checks++;
        if (seenWrites != expCount) begin
            errors++;
            $display("Error at time %0t: write count = %0d, expected %0d",
                     $time, seenWrites, expCount);
        end
    endtask

    task automatic runTest(input int mode, input string name);
        int errBase;
        int checkBase;
        errBase = errors;
        checkBase = checks;
        repeat (NUM_PROGS) begin
            genProgram(mode);
            runProgram();
        end
        $display("%s: %0d checks, %0d errors", name, checks - checkBase, errors - errBase);
    endtask

    // Every completion is compared in program order with the model's list
    always @(negedge clk) begin
        if (wbEn === 1'b1) begin
            checks++;
            seenWrites++;
            if (expReg.size() == 0) begin
                errors++;
                $display("Error at time %0t: write of %h to r%0d beyond the model's list",
                         $time, wbData, wbReg);
            end else begin
                if (wbReg !== expReg[0]) begin
                    errors++;
                    $display("Error at time %0t: wbReg = %0d, expected %0d",
                             $time, wbReg, expReg[0]);
                end
                if (wbData !== expData[0]) begin
                    errors++;
                    $display("Error at time %0t: wbData = %h, expected %h",
                             $time, wbData, expData[0]);
                end
                void'(expReg.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    // Worst case six cycles per instruction plus margin
    initial begin
        forever begin
            @(posedge clk);
            if (!running) begin
                wdCycles = 0;
            end else begin
                wdCycles++;
            end
            if (wdCycles > progLen * 6 + 200) begin
                $display("Timeout: halted not seen within %0d cycles of a %0d-word program",
                         wdCycles, progLen);
                $display("TESTS FAILED");
                $finish;
            end
        end
    end

    initial begin
        int errBase;
        int checkBase;
        rstN = 1'b0;
        errBase = errors;
        checkBase = checks;
        loadInitProgram();
        runProgram();
        $display("reset and memory init: %0d checks, %0d errors",
                 checks - checkBase, errors - errBase);
        runTest(0, "arithmetic and immediates");
        runTest(1, "memory");
        runTest(2, "control flow");
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verification/wiscPipe_sva.sv
/*
   Assertions bound into wiscPipe. The stall level is taken from inside the
   fetch stage. All checks are off while rstN is low.
*/
`timescale 1ns/1ps
module wiscPipe_sva (
    input logic        clk,
    input logic        rstN,
    input logic        pcNop,
    input logic        redirect,
    input logic [15:0] imemAddr,
    input logic        wbEn,
    input logic        halted
);

    // A stall holds the PC unless execute redirects it
    stallHoldsPc: assert property (@(posedge clk) disable iff (!rstN)
        (pcNop && !redirect) |=> $stable(imemAddr))
        else $error("imemAddr moved during a stall without a redirect");

    // HALT is the last completion of a program
    noWriteAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !wbEn)
        else $error("wbEn pulsed while halted");

    haltedSticky: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted)
        else $error("halted fell outside reset");

endmodule

bind wiscPipe wiscPipe_sva wiscPipe_sva_inst (
    .clk      (clk),
    .rstN     (rstN),
    .pcNop    (fetchStage_inst.pcNop),
    .redirect (redirect),
    .imemAddr (imemAddr),
    .wbEn     (wbEn),
    .halted   (halted)
);

// File: wiscPipe.f
hdl/wiscPkg.sv
hdl/hazardDet.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memStage.sv
hdl/wiscPipe.sv
verification/wiscPipe_sva.sv
verification/tbWiscPipe.sv
